// ==== all.f ====
hw/dcache_pkg.sv
hw/line_sweep_counter.sv
hw/dcache_store.sv
hw/lsu_align.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/dcache_mem_sim.sv
sim/dcache_asserts.sv
sim/dcache_tb.sv

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int INDEX_WID = 5
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  dcache_pkg::cpu_req_t    req,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output dcache_pkg::cpu_resp_t   resp,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output dcache_pkg::mem_req_t    mem_req,
    input  logic                    mem_resp_valid,
    input  dcache_pkg::word_t       mem_rdata,
    input  logic                    hit,
    input  logic                    victim_valid,
    input  logic                    victim_dirty,
    input  logic [13-INDEX_WID:0]   victim_tag,
    input  dcache_pkg::word_t       line_word,
    input  logic [INDEX_WID-1:0]    line_index,
    output logic                    store_we,
    output dcache_pkg::word_t       store_wdata,
    output logic                    store_dirty,
    output logic                    use_sweep_index,
    output dcache_pkg::cpu_req_t    cur_req,
    output dcache_pkg::word_t       align_word,
    input  dcache_pkg::word_t       load_result,
    input  dcache_pkg::word_t       merged_word,
    input  dcache_pkg::strb_t       wstrb,
    output logic                    sweep_start,
    output logic                    sweep_step,
    input  logic                    sweep_last
);
    import dcache_pkg::*;

    ctrl_state_e state, state_next;
    cpu_req_t    req_q;
    word_t       resp_q;
    word_t       resp_next;
    logic        is_flush;
    logic        is_store;
    logic        is_mmio;
    logic        dirty_victim;

    assign is_flush     = (req_q.op == FLUSH);
    assign is_store     = req_q.op inside {SB, SH, SW};
    assign is_mmio      = (req_q.addr[19:16] == MMIO_NIBBLE);
    assign dirty_victim = victim_valid && victim_dirty;

    assign req_ready       = (state == IDLE);
    assign resp_valid      = (state == RESPOND);
    assign resp.rdata      = resp_q;
    assign cur_req         = req_q;
    assign use_sweep_index = (state == SWEEP) ||
                             (is_flush && (state == WB_REQ || state == WB_WAIT));
    // refill and mmio data come straight off the memory bus
    assign align_word = (state == FILL_WAIT || state == IO_WAIT) ? mem_rdata : line_word;

    always_comb begin
        state_next    = state;
        resp_next     = resp_q;
        store_we      = 1'b0;
        store_wdata   = merged_word;
        store_dirty   = is_store;
        sweep_start   = 1'b0;
        sweep_step    = 1'b0;
        mem_req_valid = 1'b0;
        mem_req       = '0;
        case (state)
            IDLE: if (req_valid) state_next = LOOKUP;
            LOOKUP: begin
                if (is_flush) begin
                    sweep_start = 1'b1;
                    state_next  = SWEEP;
                end else if (is_mmio) begin
                    state_next = IO_REQ;
                end else if (hit) begin
                    store_we   = is_store;
                    resp_next  = is_store ? '0 : load_result;
                    state_next = RESPOND;
                end else begin
                    state_next = dirty_victim ? WB_REQ : FILL_REQ;
                end
            end
            WB_REQ: begin
                mem_req_valid = 1'b1;
                mem_req.addr  = {16'b0, victim_tag, line_index, 2'b00};
                mem_req.wdata = line_word;
                mem_req.wstrb = 4'hf;
                mem_req.write = 1'b1;
                if (mem_req_ready) state_next = WB_WAIT;
            end
            WB_WAIT: begin
                if (mem_resp_valid && is_flush) begin
                    // line stays valid, only the dirty bit drops
                    store_we    = 1'b1;
                    store_wdata = line_word;
                    store_dirty = 1'b0;
                    sweep_step  = !sweep_last;
                    state_next  = sweep_last ? RESPOND : SWEEP;
                end else if (mem_resp_valid) begin
                    state_next = FILL_REQ;
                end
            end
            FILL_REQ: begin
                mem_req_valid = 1'b1;
                mem_req.addr  = {16'b0, req_q.addr[15:2], 2'b00};
                if (mem_req_ready) state_next = FILL_WAIT;
            end
            FILL_WAIT: begin
                if (mem_resp_valid) begin
                    store_we   = 1'b1;
                    resp_next  = is_store ? '0 : load_result;
                    state_next = RESPOND;
                end
            end
            IO_REQ: begin
                mem_req_valid = 1'b1;
                mem_req.addr  = req_q.addr;
                mem_req.wdata = merged_word;
                mem_req.wstrb = wstrb;
                mem_req.write = is_store;
                if (mem_req_ready) state_next = IO_WAIT;
            end
            IO_WAIT: begin
                if (mem_resp_valid) begin
                    resp_next  = is_store ? '0 : load_result;
                    state_next = RESPOND;
                end
            end
            SWEEP: begin
                resp_next = '0;
                if (dirty_victim) begin
                    state_next = WB_REQ;
                end else begin
                    sweep_step = !sweep_last;
                    state_next = sweep_last ? RESPOND : SWEEP;
                end
            end
            RESPOND: if (resp_ready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
        end
        resp_q <= resp_next;
    end

endmodule

// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;

    // uncached window, addr[19:16]
    localparam logic [3:0] MMIO_NIBBLE = 4'hf;

    typedef enum logic [3:0] {
        LB    = 4'd0,
        LH    = 4'd1,
        LW    = 4'd2,
        LBU   = 4'd3,
        LHU   = 4'd4,
        SB    = 4'd5,
        SH    = 4'd6,
        SW    = 4'd7,
        FLUSH = 4'd8
    } mem_op_e;

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        IO_REQ,
        IO_WAIT,
        SWEEP,
        RESPOND
    } ctrl_state_e;

    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        mem_op_e op;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
    } cpu_resp_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  write;
    } mem_req_t;

endpackage

// ==== hw/dcache_store.sv ====
`timescale 1ns/1ps

module dcache_store #(
    parameter int INDEX_WID = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_WID-1:0]  index,
    input  logic [13-INDEX_WID:0] tag,
    input  logic                  we,
    input  dcache_pkg::word_t     wdata,
    input  logic                  set_dirty,
    output logic                  hit,
    output logic                  victim_valid,
    output logic                  victim_dirty,
    output logic [13-INDEX_WID:0] victim_tag,
    output dcache_pkg::word_t     rdata
);
    import dcache_pkg::*;

    localparam int LINES   = 1 << INDEX_WID;
    localparam int TAG_WID = 14 - INDEX_WID;

    logic [LINES-1:0]   valid_bits;
    logic [LINES-1:0]   dirty_bits;
    logic [TAG_WID-1:0] tag_mem [LINES];
    word_t              data_mem [LINES];

    // status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= set_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= wdata;
        end
    end

    assign victim_valid = valid_bits[index];
    assign victim_dirty = dirty_bits[index];
    assign victim_tag   = tag_mem[index];
    assign rdata        = data_mem[index];
    assign hit          = victim_valid && (victim_tag == tag);

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_WID = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dcache_pkg::cpu_req_t  req,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output dcache_pkg::cpu_resp_t resp,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_resp_valid,
    input  dcache_pkg::word_t     mem_rdata
);
    import dcache_pkg::*;

    localparam int TAG_WID = 14 - INDEX_WID;

    logic                 hit, victim_valid, victim_dirty;
    logic [TAG_WID-1:0]   victim_tag, store_tag;
    logic [INDEX_WID-1:0] store_index, sweep_index;
    logic                 store_we, store_dirty, use_sweep_index;
    logic                 sweep_start, sweep_step, sweep_last;
    word_t                line_word, store_wdata, align_word;
    word_t                load_result, merged_word;
    strb_t                wstrb;
    cpu_req_t             cur_req;

    // sweep rewrites a line under its own tag
    assign store_index = use_sweep_index ? sweep_index : cur_req.addr[INDEX_WID+1:2];
    assign store_tag   = use_sweep_index ? victim_tag : cur_req.addr[15:INDEX_WID+2];

    dcache_ctrl #(.INDEX_WID(INDEX_WID)) ctrl_inst (
        .clk, .rst, .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
        .mem_req_valid, .mem_req_ready, .mem_req, .mem_resp_valid, .mem_rdata,
        .hit, .victim_valid, .victim_dirty, .victim_tag, .line_word,
        .line_index(store_index), .store_we, .store_wdata, .store_dirty,
        .use_sweep_index, .cur_req, .align_word, .load_result, .merged_word, .wstrb,
        .sweep_start, .sweep_step, .sweep_last
    );

    line_sweep_counter #(.INDEX_WID(INDEX_WID)) sweep_inst (
        .clk, .rst, .start(sweep_start), .step(sweep_step),
        .index(sweep_index), .last(sweep_last)
    );

    dcache_store #(.INDEX_WID(INDEX_WID)) store_inst (
        .clk, .rst, .index(store_index), .tag(store_tag), .we(store_we),
        .wdata(store_wdata), .set_dirty(store_dirty), .hit, .victim_valid,
        .victim_dirty, .victim_tag, .rdata(line_word)
    );

    lsu_align align_inst (
        .op(cur_req.op), .byte_off(cur_req.addr[1:0]), .wdata(cur_req.wdata),
        .old_word(align_word), .load_result, .merged_word, .wstrb
    );

endmodule

// ==== hw/line_sweep_counter.sv ====
`timescale 1ns/1ps

module line_sweep_counter #(
    parameter int INDEX_WID = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 step,
    output logic [INDEX_WID-1:0] index,
    output logic                 last
);

    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else if (start) begin
            index <= '0;
        end else if (step) begin
            index <= index + 1'b1;
        end
    end

    // final line of the array
    assign last = &index;

endmodule

// ==== hw/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align (
    input  dcache_pkg::mem_op_e op,
    input  logic [1:0]          byte_off,
    input  dcache_pkg::word_t   wdata,
    input  dcache_pkg::word_t   old_word,
    output dcache_pkg::word_t   load_result,
    output dcache_pkg::word_t   merged_word,
    output dcache_pkg::strb_t   wstrb
);
    import dcache_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t       lanes;

    assign sel_byte = old_word[8*byte_off +: 8];
    assign sel_half = byte_off[1] ? old_word[31:16] : old_word[15:0];

    // load extraction
    always_comb begin
        case (op)
            LB:      load_result = {{24{sel_byte[7]}}, sel_byte};
            LBU:     load_result = {24'h0, sel_byte};
            LH:      load_result = {{16{sel_half[15]}}, sel_half};
            LHU:     load_result = {16'h0, sel_half};
            LW:      load_result = old_word;
            default: load_result = '0;
        endcase
    end

    // store data replicated across lanes, strobe picks the live ones
    always_comb begin
        case (op)
            SB: begin
                lanes = {4{wdata[7:0]}};
                wstrb = 4'b0001 << byte_off;
            end
            SH: begin
                lanes = {2{wdata[15:0]}};
                wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                lanes = wdata;
                wstrb = 4'b1111;
            end
            default: begin
                lanes = '0;
                wstrb = 4'b0000;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged_word[8*i +: 8] = wstrb[i] ? lanes[8*i +: 8] : old_word[8*i +: 8];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dcache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module dcache_tb -f all.f -o Vdcache_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vdcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "result: fail"
    exit 1
fi

echo "result: pass"
exit 0

// ==== sim/dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
    input logic                    clk,
    input logic                    rst,
    input logic                    req_valid,
    input logic                    req_ready,
    input dcache_pkg::cpu_req_t    req,
    input logic                    resp_valid,
    input logic                    resp_ready,
    input dcache_pkg::cpu_resp_t   resp,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input dcache_pkg::mem_req_t    mem_req,
    input dcache_pkg::ctrl_state_e state
);
    import dcache_pkg::*;

    req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("cpu request dropped or changed before ready");

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response dropped or changed while stalled");

    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request dropped or changed before ready");

    accept_lookup: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |=> state == LOOKUP)
        else $error("accepted request did not move to LOOKUP");

    // ready comes back only once the response is taken
    ready_after_resp: assert property (@(posedge clk) disable iff (rst)
        !req_ready && !(resp_valid && resp_ready) |=> !req_ready)
        else $error("req_ready rose while a request was still in flight");

    // state right after a reset edge
    reset_state: assert property (@(posedge clk)
        rst |=> req_ready && !resp_valid && !mem_req_valid)
        else $error("bad handshake state after reset");

endmodule

bind dcache_ctrl dcache_asserts asserts_inst (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready), .req(req),
    .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
    .state(state)
);

// ==== sim/dcache_mem_sim.sv ====
`timescale 1ns/1ps

module dcache_mem_sim (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req_valid,
    output logic                 mem_req_ready,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_resp_valid,
    output dcache_pkg::word_t    mem_rdata
);
    import dcache_pkg::*;

    // addr[17:2] keeps the low 64 KB and the mmio window apart
    word_t  words [65536];
    int     rd_count;
    int     wr_count;
    int     mmio_count;
    logic   busy;
    int     wait_cnt;
    integer seed = 32'hdcd999b9;

    initial begin
        logic [15:0] idx;
        for (int i = 0; i < 65536; i++) begin
            idx = 16'(i);
            words[i] = {idx ^ 16'ha5c3, idx[7:0], ~idx[15:8]};
        end
    end

    assign mem_req_ready = !busy;

    always @(posedge clk) begin
        mem_resp_valid <= 1'b0;
        if (rst) begin
            busy       <= 1'b0;
            wait_cnt   <= 0;
            rd_count   <= 0;
            wr_count   <= 0;
            mmio_count <= 0;
            mem_rdata  <= '0;
        end else if (!busy) begin
            if (mem_req_valid) begin
                busy     <= 1'b1;
                wait_cnt <= int'($unsigned($random(seed)) % 6);
                if (mem_req.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.wstrb[b]) begin
                            words[mem_req.addr[17:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                        end
                    end
                    wr_count <= wr_count + 1;
                end else begin
                    mem_rdata <= words[mem_req.addr[17:2]];
                    rd_count  <= rd_count + 1;
                end
                if (mem_req.addr[19:16] == MMIO_NIBBLE) mmio_count <= mmio_count + 1;
            end
        end else if (wait_cnt == 0) begin
            mem_resp_valid <= 1'b1;
            busy           <= 1'b0;
        end else begin
            wait_cnt <= wait_cnt - 1;
        end
    end

endmodule

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int INDEX_WID  = 5;
    localparam int TOTAL_REQS = 871;

    logic      clk, rst;
    logic      req_valid, req_ready, resp_valid, resp_ready;
    cpu_req_t  req;
    cpu_resp_t resp;
    logic      mem_req_valid, mem_req_ready, mem_resp_valid;
    mem_req_t  mem_req;
    word_t     mem_rdata;

    logic [7:0] ref_mem [262144];
    integer     seed = 32'hdcd999b9;
    int         errors, test_errors, tests_run, tests_failed;
    logic       bp_on;
    mem_op_e    cur_op;
    addr_t      cur_addr;
    addr_t      written_q [$];

    dcache_top #(.INDEX_WID(INDEX_WID)) dcache_top_inst (
        .clk, .rst, .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
        .mem_req_valid, .mem_req_ready, .mem_req, .mem_resp_valid, .mem_rdata
    );

    dcache_mem_sim mem_inst (
        .clk, .rst, .mem_req_valid, .mem_req_ready, .mem_req, .mem_resp_valid, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TOTAL_REQS * 100 + 20) @(posedge clk);
        $display("timeout: the cache stopped answering requests");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic word_t ref_word(addr_t a);
        return {ref_mem[{a[17:2], 2'd3}], ref_mem[{a[17:2], 2'd2}],
                ref_mem[{a[17:2], 2'd1}], ref_mem[{a[17:2], 2'd0}]};
    endfunction

    function automatic word_t expected_load(mem_op_e op, addr_t a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[a[17:0]];
        h = {ref_mem[{a[17:1], 1'b1}], ref_mem[{a[17:1], 1'b0}]};
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            LW:      return ref_word(a);
            default: return '0;
        endcase
    endfunction

    function automatic strb_t expected_strb(mem_op_e op, addr_t a);
        int    size;
        strb_t s;
        case (op)
            SB:      size = 1;
            SH:      size = 2;
            SW:      size = 4;
            default: size = 0;
        endcase
        s = '0;
        // one enable per byte the store covers
        for (int i = 0; i < size; i++) s[a[1:0] + i] = 1'b1;
        return s;
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op == SB || op == SH || op == SW;
    endfunction

    task automatic report_mismatch(string name, word_t got, word_t exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        test_errors++;
    endtask

    task automatic report_failure(string what);
        $display("error at %0t: %s", $time, what);
        test_errors++;
    endtask

    // every accepted memory request, seen where it is stable
    always @(negedge clk) begin
        if (!rst && mem_req_valid && mem_req_ready) begin
            if (mem_req.addr[19:16] == MMIO_NIBBLE) begin
                if (mem_req.wstrb != expected_strb(cur_op, cur_addr))
                    report_mismatch("mem_req.wstrb", 32'(mem_req.wstrb),
                                    32'(expected_strb(cur_op, cur_addr)));
                if (mem_req.write != is_store(cur_op))
                    report_mismatch("mem_req.write", 32'(mem_req.write), 32'(is_store(cur_op)));
                if (mem_req.addr != cur_addr)
                    report_mismatch("mem_req.addr", mem_req.addr, cur_addr);
            end else if (mem_req.write && mem_req.wdata != ref_word(mem_req.addr)) begin
                report_mismatch("mem_req.wdata", mem_req.wdata, ref_word(mem_req.addr));
            end
        end
    end

    task automatic do_req(input mem_op_e op, input addr_t a, input word_t d);
        int    mmio_before;
        int    acc_before;
        int    mmio_exp;
        word_t first;
        logic  seen;
        logic  done;
        mmio_before = mem_inst.mmio_count;
        acc_before  = mem_inst.rd_count + mem_inst.wr_count;
        cur_op      = op;
        cur_addr    = a;
        @(negedge clk);
        req_valid = 1'b1;
        req.addr  = a;
        req.wdata = d;
        req.op    = op;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        seen = 1'b0;
        done = 1'b0;
        first = '0;
        while (!done) begin
            resp_ready = bp_on ? $random(seed) % 2 != 0 : 1'b1;
            if (resp_valid) begin
                if (!seen) begin
                    first = resp.rdata;
                    seen  = 1'b1;
                end else if (resp.rdata != first) begin
                    report_mismatch("resp.rdata (stalled)", resp.rdata, first);
                end
                done = resp_ready;
            end
            @(negedge clk);
        end
        resp_ready = 1'b0;
        if (resp_valid) report_failure("response presented twice for one request");
        if (is_store(op) || op == FLUSH) begin
            if (first != '0) report_mismatch("resp.rdata", first, '0);
        end else if (first != expected_load(op, a)) begin
            report_mismatch("resp.rdata", first, expected_load(op, a));
        end
        // update the reference after the response
        case (op)
            SB: ref_mem[a[17:0]] = d[7:0];
            SH: begin
                ref_mem[{a[17:1], 1'b0}] = d[7:0];
                ref_mem[{a[17:1], 1'b1}] = d[15:8];
            end
            SW: for (int i = 0; i < 4; i++) ref_mem[{a[17:2], 2'(i)}] = d[8*i +: 8];
            default: ;
        endcase
        if (is_store(op)) written_q.push_back(a);
        mmio_exp = (op != FLUSH && a[19:16] == MMIO_NIBBLE) ? 1 : 0;
        if (mem_inst.mmio_count - mmio_before != mmio_exp)
            report_failure("wrong number of mmio transactions for one request");
        if (mmio_exp == 1 && mem_inst.rd_count + mem_inst.wr_count - acc_before != 1)
            report_failure("mmio access did not give exactly one memory transaction");
        if (op == FLUSH) begin
            foreach (written_q[i]) begin
                if (mem_inst.words[written_q[i][17:2]] != ref_word(written_q[i]))
                    report_mismatch("memory after flush",
                                    mem_inst.words[written_q[i][17:2]], ref_word(written_q[i]));
            end
        end
    endtask

    task automatic rand_access(input addr_t base, input int span, input logic stores_only);
        mem_op_e op;
        addr_t   a;
        word_t   d;
        op = mem_op_e'(4'($unsigned($random(seed)) % 8));
        if (stores_only) op = mem_op_e'(4'(5 + $unsigned($random(seed)) % 3));
        a = base + addr_t'($unsigned($random(seed)) % span);
        if (op == LH || op == LHU || op == SH) a[0] = 1'b0;
        if (op == LW || op == SW) a[1:0] = 2'b00;
        d = $random(seed);
        do_req(op, a, d);
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        errors += test_errors;
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        addr_t a;
        word_t d;
        int    k;
        int    r;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b0;
        bp_on = 1'b0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_op = LW;
        cur_addr = '0;
        for (int i = 0; i < 262144; i++) begin
            ref_mem[i] = 8'(({16'(i >> 2) ^ 16'ha5c3, 8'(i >> 2), ~8'(i >> 10)}
                             >> (8 * (i % 4))));
        end
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (200) rand_access(32'h0000_0100, 16, 1'b0);
        finish_test("local_ops");
        repeat (300) rand_access(32'h0, 65536, 1'b0);
        finish_test("spread_misses");

        repeat (10) begin
            a = addr_t'($unsigned($random(seed)) % 65536) & 32'h0000_fffc;
            d = $random(seed);
            k = 1 + int'($unsigned($random(seed)) % 511);
            do_req(SW, a, d);
            // same index, different tag
            do_req(LW, a ^ (addr_t'(k) << (INDEX_WID + 2)), '0);
            if (mem_inst.words[a[17:2]] != d)
                report_mismatch("memory after eviction", mem_inst.words[a[17:2]], d);
            do_req(LW, a, '0);
        end
        finish_test("dirty_eviction");

        repeat (100) rand_access(32'h000f_0000, 256, 1'b0);
        finish_test("mmio_bypass");

        repeat (40) rand_access(32'h0, 65536, 1'b1);
        do_req(FLUSH, '0, '0);
        finish_test("flush");

        bp_on = 1'b1;
        repeat (200) begin
            r = int'($unsigned($random(seed)) % 16);
            if (r == 0) do_req(FLUSH, '0, '0);
            else if (r == 1) rand_access(32'h000f_0000, 64, 1'b0);
            else rand_access(32'h0, 1024, 1'b0);
        end
        bp_on = 1'b0;
        finish_test("back_pressure");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
